//--- Bender.yml
package:
  name: otter_memory

export_include_dirs:
  - hdl

sources:
  # Synthesizable memory
  - include_dirs:
      - hdl
    files:
      - hdl/memPkg.sv
      - hdl/storeSteer.sv
      - hdl/byteLaneBank.sv
      - hdl/loadExtractor.sv
      - hdl/otterMemory.sv
  # Testbench
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tb/memTb.sv

//--- hdl/byteLaneBank.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

// One byte lane: data R/W port plus instruction read port
module byteLaneBank import memPkg::*; (
    input  logic     MEM_CLK,
    input  logic     arstN,
    input  logic     wrEn,
    input  wordAddrT wrAddr,      // Also the data read index
    input  byteT     wrData,
    input  logic     dataRden,
    input  logic     instRden,
    input  wordAddrT instAddr,
    output byteT     dataByte,
    output byteT     instByte
);

    byteT mem [0:(1 << `MEM_WORDS_LOG2)-1];

    // Storage, block RAM style
    always_ff @(posedge MEM_CLK) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    ////////////////////
    // Read registers
    ////////////////////
    // Nonblocking write above keeps these read-first
    always_ff @(posedge MEM_CLK or negedge arstN) begin
        if (!arstN) begin
            dataByte <= '0;
            instByte <= '0;
        end else begin
            if (dataRden) begin
                dataByte <= mem[wrAddr];
            end
            if (instRden) begin
                instByte <= mem[instAddr];   // Fetch port
            end
        end
    end

endmodule

//--- hdl/loadExtractor.sv
`timescale 1ns/100ps

// Lines load control up with bank data, then sizes and extends
module loadExtractor import memPkg::*; (
    input  logic    MEM_CLK,
    input  logic    arstN,
    input  loadCtlT loadCtl,
    input  wordT    ioIn,
    input  wordT    bankWord,
    output wordT    dataOut
);

    loadCtlT ctlQ;      // Control of the load now on bankWord
    wordT    ioBuf;
    wordT    shifted;   // Addressed byte moved down to bit 0
    wordT    sized;
    logic    signBit;

    ////////////////////
    // Stage registers
    ////////////////////
    always_ff @(posedge MEM_CLK or negedge arstN) begin
        if (!arstN) begin
            ctlQ  <= '0;
            ioBuf <= '0;
        end else begin
            if (loadCtl.rden) begin
                ctlQ <= loadCtl;         // Held until next load
            end
            if (loadCtl.rden && loadCtl.isIo) begin
                ioBuf <= ioIn;           // IO sampled at the load edge
            end
        end
    end

    assign shifted = bankWord >> {ctlQ.offset, 3'b000};

    // Size select and extension
    always_comb begin
        signBit = 1'b0;
        sized   = '0;
        case (ctlQ.size)
            SIZE_BYTE: begin
                signBit = shifted[7] & ~ctlQ.unsignedLd;
                sized   = {{24{signBit}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                signBit = shifted[15] & ~ctlQ.unsignedLd;
                if (ctlQ.offset != 2'd3) begin
                    sized = {{16{signBit}}, shifted[15:0]};
                end
            end
            SIZE_WORD: begin
                if (ctlQ.offset == 2'd0) begin
                    sized = bankWord;    // No extension
                end
            end
            default: sized = '0;         // Unsupported size
        endcase
    end

    ////////////////////
    // Result mux
    ////////////////////
    always_comb begin
        if (!ctlQ.rden) begin
            dataOut = '0;                // No load seen yet
        end else if (ctlQ.isIo) begin
            dataOut = ioBuf;
        end else begin
            dataOut = sized;
        end
    end

endmodule

//--- hdl/memPkg.sv
`include "mem_macros.svh"

package memPkg;

    ////////////////////
    // Plain vectors
    ////////////////////
    typedef logic [31:0]                  addrT;     // Byte address
    typedef logic [31:0]                  wordT;
    typedef logic [7:0]                   byteT;
    typedef logic [`MEM_WORDS_LOG2-1:0]   wordAddrT; // Word index into the array
    typedef logic [`BYTE_LANES-1:0]       laneEnT;   // One bit per bank
    typedef logic [`BYTE_OFF_MSB:0]       byteOffT;
    typedef logic [1:0]                   accSizeT;

    // Access size codes, as on the RV32I funct3 low bits
    localparam accSizeT SIZE_BYTE = 2'd0;
    localparam accSizeT SIZE_HALF = 2'd1;
    localparam accSizeT SIZE_WORD = 2'd2;   // 3 is unsupported

    ////////////////////
    // Bundles
    ////////////////////
    typedef struct packed {
        addrT    addr;
        wordT    wdata;
        accSizeT size;
        logic    unsignedLd;  // 1 = zero extend
        logic    we;
        logic    rden;
    } dataReqT;

    typedef struct packed {
        wordAddrT                 wordAddr;
        laneEnT                   laneEn;
        byteT [`BYTE_LANES-1:0]   laneData;  // Already moved onto its lane
    } laneWrT;

    typedef struct packed {
        byteOffT offset;
        accSizeT size;
        logic    unsignedLd;
        logic    isIo;       // Take the IO buffer, not the banks
        logic    rden;
    } loadCtlT;

endpackage

//--- hdl/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Memory geometry
`define MEM_WORDS_LOG2  14              // 16384 words
`define BYTE_LANES      4               // Bytes per word, one bank each

// Start of memory-mapped IO, byte address
`define MMIO_BASE       32'h00010000

// Where the fields sit in a data-port byte address
`define BYTE_OFF_MSB    1               // addr[1:0] picks the lane
`define WORD_ADDR_LSB   2
`define WORD_ADDR_MSB   (`WORD_ADDR_LSB + `MEM_WORDS_LOG2 - 1)

`endif

//--- hdl/otterMemory.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

// Unified instruction/data memory with MMIO
module otterMemory import memPkg::*; (
    input  logic     MEM_CLK,
    input  logic     arstN,
    input  dataReqT  dataReq,
    input  logic     instRden,
    input  wordAddrT instAddr,    // Word index, PC[15:2]
    input  wordT     ioIn,
    output logic     ioWr,
    output wordT     dataOut,
    output wordT     instData
);

    laneWrT   laneWr;
    wordAddrT dataRdAddr;
    loadCtlT  loadCtl;
    wordT     bankWord;   // Raw data word from the four lanes

    ////////////////////
    // Request decode
    ////////////////////
    storeSteer steer (
        .dataReq    (dataReq),
        .laneWr     (laneWr),
        .dataRdAddr (dataRdAddr),
        .loadCtl    (loadCtl),
        .ioWr       (ioWr)
    );

    ////////////////////
    // Byte lanes
    ////////////////////
    for (genvar i = 0; i < `BYTE_LANES; i++) begin : genLane
        byteLaneBank bank (
            .MEM_CLK  (MEM_CLK),
            .arstN    (arstN),
            .wrEn     (laneWr.laneEn[i]),
            .wrAddr   (dataRdAddr),
            .wrData   (laneWr.laneData[i]),
            .dataRden (dataReq.rden),
            .instRden (instRden),
            .instAddr (instAddr),
            .dataByte (bankWord[8*i +: 8]),   // Lane i is byte i
            .instByte (instData[8*i +: 8])
        );
    end

    ////////////////////
    // Load path
    ////////////////////
    loadExtractor extract (
        .MEM_CLK  (MEM_CLK),
        .arstN    (arstN),
        .loadCtl  (loadCtl),
        .ioIn     (ioIn),
        .bankWord (bankWord),
        .dataOut  (dataOut)
    );

endmodule

//--- hdl/storeSteer.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

// Data-port decode: bank writes, IO strobe, load record
module storeSteer import memPkg::*; (
    input  dataReqT  dataReq,
    output laneWrT   laneWr,
    output wordAddrT dataRdAddr,
    output loadCtlT  loadCtl,
    output logic     ioWr
);

    wordAddrT wordAddr;
    byteOffT  offset;
    logic     isIo;
    logic     memWe;        // Store aimed at the RAM range
    laneEnT   sizeMask;     // Lanes the access covers, ungated
    wordT     shiftedData;

    ////////////////////
    // Address split
    ////////////////////
    assign wordAddr = dataReq.addr[`WORD_ADDR_MSB:`WORD_ADDR_LSB];
    assign offset   = dataReq.addr[`BYTE_OFF_MSB:0];
    assign isIo     = (dataReq.addr >= `MMIO_BASE);   // Only MMIO decode in the design

    assign ioWr  = dataReq.we & isIo;    // Same-cycle strobe
    assign memWe = dataReq.we & ~isIo;

    // Lane coverage per size and offset
    always_comb begin
        sizeMask = '0;
        case (dataReq.size)
            SIZE_BYTE: sizeMask = laneEnT'(4'b0001 << offset);
            SIZE_HALF: begin
                if (offset != 2'd3) begin        // Half may not cross the word
                    sizeMask = laneEnT'(4'b0011 << offset);
                end
            end
            SIZE_WORD: begin
                if (offset == 2'd0) begin
                    sizeMask = '1;
                end
            end
            default: sizeMask = '0;              // Size 3, nothing written
        endcase
    end

    // Low bytes of wdata slide up to the addressed lane
    assign shiftedData = dataReq.wdata << {offset, 3'b000};

    ////////////////////
    // Outputs
    ////////////////////
    always_comb begin
        laneWr.wordAddr = wordAddr;
        laneWr.laneEn   = memWe ? sizeMask : '0;
        laneWr.laneData = shiftedData;
    end

    assign dataRdAddr = wordAddr;    // Read and write share the index

    always_comb begin
        loadCtl.offset     = offset;
        loadCtl.size       = dataReq.size;
        loadCtl.unsignedLd = dataReq.unsignedLd;
        loadCtl.isIo       = isIo;
        loadCtl.rden       = dataReq.rden;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/memPkg.sv
hdl/storeSteer.sv
hdl/byteLaneBank.sv
hdl/loadExtractor.sv
hdl/otterMemory.sv
tb/memTb.sv

//--- tb/memTb.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module memTb import memPkg::*; ();

    localparam int WINDOW_WORDS = 256;   // Words the RAM traffic touches
    localparam int DRAIN_LIMIT  = 8;

    logic     MEM_CLK;
    logic     arstN;
    dataReqT  dataReq;
    logic     instRden;
    wordAddrT instAddr;
    wordT     ioIn;
    logic     ioWr;
    wordT     dataOut;
    wordT     instData;

    byteT        refMem [0:65535];   // Byte image of the RAM range
    logic [15:0] lfsr;
    wordT        expData;            // Set when a load is issued
    wordT        expInst;
    wordT        expDataQ;           // Lined up with the check edge
    wordT        expInstQ;
    logic        expIoWr;
    logic        idleCheck;
    int          dataErrs;
    int          instErrs;
    int          ioErrs;
    int          idleErrs;
    int          timeoutErrs;

    otterMemory UUT (.*);

    always #5 MEM_CLK = ~MEM_CLK;

    always @(posedge MEM_CLK) begin
        expDataQ <= expData;
        expInstQ <= expInst;
    end

    ////////////////////
    // Checks
    ////////////////////
    chkIdle: assert property (@(posedge MEM_CLK) disable iff (!arstN)
            idleCheck |-> (dataOut == '0 && instData == '0 && !ioWr))
        else begin
            idleErrs++;
            $display("MISMATCH after reset dataOut %h instData %h ioWr %h exp 0",
                     $sampled(dataOut), $sampled(instData), $sampled(ioWr));
        end

    chkLoad: assert property (@(posedge MEM_CLK) disable iff (!arstN)
            dataReq.rden |=> dataOut == expDataQ)
        else begin
            dataErrs++;
            $display("MISMATCH dataOut got %h exp %h", $sampled(dataOut), $sampled(expDataQ));
        end

    chkFetch: assert property (@(posedge MEM_CLK) disable iff (!arstN)
            instRden |=> instData == expInstQ)
        else begin
            instErrs++;
            $display("MISMATCH instData got %h exp %h",
                     $sampled(instData), $sampled(expInstQ));
        end

    // Combinational strobe, compared every edge
    chkIoWr: assert property (@(posedge MEM_CLK) ioWr == expIoWr)
        else begin
            ioErrs++;
            $display("MISMATCH ioWr got %h exp %h", $sampled(ioWr), $sampled(expIoWr));
        end

    ////////////////////
    // Model
    ////////////////////
    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic addrT randAddr();   // Byte inside the window
        return addrT'(randBits(10));
    endfunction

    // Byte anywhere, half not across the word, word aligned only
    function automatic logic legal(input accSizeT sz, input logic [1:0] off);
        case (sz)
            2'd0:    return 1'b1;
            2'd1:    return off != 2'd3;
            2'd2:    return off == 2'd0;
            default: return 1'b0;
        endcase
    endfunction

    function automatic wordT modelLoad(input addrT a, input accSizeT sz, input logic uns);
        logic [15:0] b;
        logic [15:0] h;
        b = a[15:0];
        h = {refMem[b + 16'd1], refMem[b]};
        if (!legal(sz, a[1:0])) return '0;
        case (sz)
            2'd0:    return uns ? {24'b0, h[7:0]} : {{24{h[7]}}, h[7:0]};
            2'd1:    return uns ? {16'b0, h} : {{16{h[15]}}, h};
            default: return {refMem[b + 16'd3], refMem[b + 16'd2], h};
        endcase
    endfunction

    function automatic void modelStore(input addrT a, input wordT d, input accSizeT sz);
        if (legal(sz, a[1:0])) begin
            for (int i = 0; i < (1 << sz); i++) begin
                refMem[a[15:0] + 16'(i)] = d[8*i +: 8];
            end
        end
    endfunction

    function automatic wordT instWord(input wordAddrT w);
        return {refMem[{w, 2'd3}], refMem[{w, 2'd2}], refMem[{w, 2'd1}], refMem[{w, 2'd0}]};
    endfunction

    ////////////////////
    // Stimulus tasks
    ////////////////////
    task automatic access(input addrT addr, input wordT wdata, input accSizeT size,
                          input logic uns, input logic we, input logic rden,
                          input logic iRd, input wordAddrT iAddr, input wordT io);
        dataReqT req;
        logic    isIo;
        @(posedge MEM_CLK);
        isIo = (addr >= `MMIO_BASE);
        // Expectations taken before this access's own store
        if (rden) begin
            expData <= isIo ? io : modelLoad(addr, size, uns);
        end
        if (iRd) begin
            expInst <= instWord(iAddr);
        end
        expIoWr <= we & isIo;
        if (we && !isIo) begin
            modelStore(addr, wdata, size);
        end
        req.addr       = addr;
        req.wdata      = wdata;
        req.size       = size;
        req.unsignedLd = uns;
        req.we         = we;
        req.rden       = rden;
        dataReq  <= req;
        instRden <= iRd;
        instAddr <= iAddr;
        ioIn     <= io;
    endtask

    task automatic store(input addrT a, input wordT d, input accSizeT sz);
        access(a, d, sz, 1'b0, 1'b1, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic load(input addrT a, input accSizeT sz, input logic uns);
        access(a, '0, sz, uns, 1'b0, 1'b1, 1'b0, '0, '0);
    endtask

    // Idle the ports, let the last checks fire
    task automatic drainIdle();
        int   cycles;
        logic settled;
        access('0, '0, SIZE_BYTE, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        cycles  = 0;
        settled = 1'b0;
        while (!settled && cycles < DRAIN_LIMIT) begin
            @(posedge MEM_CLK);
            cycles++;
            settled = (ioWr === 1'b0) && (cycles >= 3);
        end
        if (!settled) begin
            timeoutErrs++;
            $display("Timeout: ioWr stayed high after the last access");
        end
    endtask

    task automatic finishRun();
        $display("Errors: data %0d inst %0d ioWr %0d idle %0d timeout %0d",
                 dataErrs, instErrs, ioErrs, idleErrs, timeoutErrs);
        if (dataErrs + instErrs + ioErrs + idleErrs + timeoutErrs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    ////////////////////
    // Sequence
    ////////////////////
    initial begin
        addrT a;
        MEM_CLK     = 1'b0;
        arstN       = 1'b0;
        dataReq     = '0;
        instRden    = 1'b0;
        instAddr    = '0;
        ioIn        = '0;
        lfsr        = 16'd29;
        expData     = '0;
        expInst     = '0;
        expIoWr     = 1'b0;
        idleCheck   = 1'b0;
        dataErrs    = 0;
        instErrs    = 0;
        ioErrs      = 0;
        idleErrs    = 0;
        timeoutErrs = 0;
        repeat (16) @(posedge MEM_CLK);
        arstN     <= 1'b1;
        idleCheck <= 1'b1;   // Outputs must sit at zero here
        repeat (4) @(posedge MEM_CLK);
        idleCheck <= 1'b0;

        // Fill the window, no load may hit an unwritten byte
        for (int w = 0; w < WINDOW_WORDS; w++) begin
            store(addrT'(w) << 2, randBits(32), SIZE_WORD);
        end
        // Word round trip, data and fetch port together
        for (int n = 0; n < 8; n++) begin
            a = randAddr() & ~32'h3;
            store(a, randBits(32), SIZE_WORD);
            access(a, '0, SIZE_WORD, 1'b0, 1'b0, 1'b1, 1'b1, a[15:2], '0);
        end
        // Every size and offset, both extensions
        for (int sz = 0; sz < 4; sz++) begin
            for (int off = 0; off < 4; off++) begin
                for (int u = 0; u < 2; u++) begin
                    a = (randAddr() & ~32'h3) | addrT'(off);
                    store(a, randBits(32), accSizeT'(sz));
                    load(a, accSizeT'(sz), 1'(u));
                    load(a & ~32'h3, SIZE_WORD, 1'b0);   // Neighbour bytes intact
                end
            end
        end
        // MMIO aliases of RAM words
        for (int n = 0; n < 6; n++) begin
            a = randAddr() & ~32'h3;
            store(a | `MMIO_BASE, randBits(32), SIZE_WORD);
            access(a | `MMIO_BASE, '0, SIZE_WORD, 1'b0, 1'b0, 1'b1, 1'b0, '0, randBits(32));
            load(a, SIZE_WORD, 1'b0);
        end
        // Same edge traffic on both ports
        for (int n = 0; n < 6; n++) begin
            a = randAddr() & ~32'h3;
            access(a, randBits(32), SIZE_WORD, 1'b0, 1'b1, 1'b0, 1'b1, a[15:2], '0);
            access(a, '0, SIZE_WORD, 1'b0, 1'b0, 1'b1, 1'b1,
                   wordAddrT'(((a >> 2) + 1) % WINDOW_WORDS), '0);
        end
        // Random mix, one in eight to IO
        for (int n = 0; n < 300; n++) begin
            a = randAddr();
            if (randBits(3) == 0) begin
                a = a | `MMIO_BASE;
            end
            access(a, randBits(32), accSizeT'(randBits(2)), 1'(randBits(1)), 1'(randBits(1)),
                   1'(randBits(1)), 1'(randBits(1)), wordAddrT'(randBits(8)), randBits(32));
        end
        drainIdle();
        finishRun();
    end

endmodule
